// ==== sim.f ====
+incdir+.
ex_pkg.sv
ex_issue_stage.sv
ex_alu_lane.sv
ex_vote_stage.sv
ex_writeback_stage.sv
ex_stage_ft.sv
ex_stage_ft_chk.sv
tb_ex_stage_ft.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ex_stage_ft
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_ex_stage_ft.sv ====
/* Testbench for the FT execute stage
   Random ALU ops checked against a four-lane model with vote and fault counters */

`default_nettype none

`include "ex_defines.svh"

module tb_ex_stage_ft import ex_pkg::*; ();

  localparam int unsigned TIMEOUT_CYC = 3000;

  typedef struct packed {
    logic [31:0]                          cyc;
    logic [`EX_REG_ADDR_W-1:0]            waddr;
    logic                                 we;
    logic [`EX_DATA_W-1:0]                wdata;
    logic                                 br;
    logic                                 corr;
    logic                                 det;
    logic [`EX_LANES-1:0]                 pulse;
    logic [`EX_LANES-1:0]                 perm;
    logic [`EX_LANES-1:0][`EX_FCNT_W-1:0] cnt;
  } exp_t;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 valid_i;
  alu_op_e                              alu_op_i;
  logic [`EX_DATA_W-1:0]                operand_a_i;
  logic [`EX_DATA_W-1:0]                operand_b_i;
  logic [`EX_REG_ADDR_W-1:0]            alu_waddr_i;
  logic                                 alu_we_i;
  logic                                 csr_access_i;
  logic [`EX_DATA_W-1:0]                csr_rdata_i;
  logic [`EX_LANES-1:0]                 lane_clk_en_i;
  logic [`EX_LANE_IDX_W-1:0]            excl_lane_i;
  logic                                 wb_valid_o;
  logic [`EX_REG_ADDR_W-1:0]            alu_waddr_fw_o;
  logic                                 alu_we_fw_o;
  logic [`EX_DATA_W-1:0]                alu_wdata_fw_o;
  logic                                 branch_decision_o;
  logic                                 err_corrected_o;
  logic                                 err_detected_o;
  logic [`EX_LANES-1:0][`EX_FCNT_W-1:0] fault_cnt_o;
  logic [`EX_LANES-1:0]                 perm_faulty_o;
  logic [`EX_LANES-1:0]                 fault_pulse_o;
  // Model state, lane registers hold the comparison bit on top
  logic [`EX_LANES-1:0][`EX_DATA_W:0]   model_lane = '0;
  logic [`EX_LANES-1:0][`EX_FCNT_W-1:0] model_cnt = '0;
  exp_t                                 exp_q[$];
  int unsigned                          cyc = 0;
  int unsigned                          n_corr = 0;
  int unsigned                          n_det = 0;

  ex_stage_ft ex_stage_ft_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Error reporting
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Returns {cmp, result}
  function automatic logic [32:0] alu_ref(input alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [4:0]  sh;
    logic        lt_s;
    logic        cmp;
    logic [31:0] res;
    sh   = b[4:0];
    // Signed order by flipping both sign bits
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    cmp  = 1'b0;
    res  = '0;
    case (op)
      alu_add:          res = a + b;
      alu_sub:          res = a - b;
      alu_and:          res = a & b;
      alu_or:           res = a | b;
      alu_xor:          res = a ^ b;
      alu_sll:          res = a << sh;
      alu_srl:          res = a >> sh;
      alu_sra:          res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      alu_slt, alu_lt:  cmp = lt_s;
      alu_sltu, alu_ltu: cmp = a < b;
      alu_eq:           cmp = a == b;
      alu_ne:           cmp = a != b;
      alu_ge:           cmp = !lt_s;
      default:          cmp = !(a < b);
    endcase
    // Comparison group returns the flag zero-extended
    if (op >= alu_slt) begin
      res = {31'b0, cmp};
    end
    return {cmp, res};
  endfunction

  function automatic logic [32:0] vote_ref(input logic [3:0][32:0] lanes, input logic [1:0] excl,
                                           output vote_status_e status, output logic [1:0] dissent);
    logic [1:0] ip;
    logic [1:0] iq;
    logic [1:0] ir;
    int         n;
    n  = 0;
    ip = 2'd0;
    iq = 2'd0;
    ir = 2'd0;
    for (int l = 0; l < `EX_LANES; l++) begin
      if (2'(l) != excl) begin
        if (n == 0) ip = 2'(l);
        else if (n == 1) iq = 2'(l);
        else ir = 2'(l);
        n++;
      end
    end
    status  = vote_corrected;
    dissent = ip;
    if (lanes[ip] == lanes[iq] && lanes[iq] == lanes[ir]) status = vote_ok;
    else if (lanes[ip] == lanes[iq]) dissent = ir;
    else if (lanes[ip] == lanes[ir]) dissent = iq;
    else if (lanes[iq] == lanes[ir]) return lanes[iq];
    else status = vote_failed;
    return lanes[ip];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive(input logic v, input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                       input logic [3:0] en, input logic [1:0] excl, input logic csr);
    @(posedge clk);
    valid_i       <= v;
    alu_op_i      <= op;
    operand_a_i   <= a;
    operand_b_i   <= b;
    alu_waddr_i   <= `EX_REG_ADDR_W'($urandom);
    alu_we_i      <= 1'($urandom);
    csr_access_i  <= csr;
    csr_rdata_i   <= $urandom;
    lane_clk_en_i <= en;
    excl_lane_i   <= excl;
  endtask

  task automatic random_ops(input int n, input logic [3:0] en, input logic [1:0] excl,
                            input int unsigned csr_pct);
    logic [31:0] a;
    logic [31:0] b;
    repeat (n) begin
      a = $urandom;
      // Equal operands now and then so eq and ge see both outcomes
      b = ($urandom_range(3, 0) == 0) ? a : $urandom;
      drive($urandom_range(99, 0) < 70, alu_op_e'(4'($urandom)), a, b, en, excl,
            $urandom_range(99, 0) < csr_pct);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor, pre-edge values on every rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : monitor
    exp_t         rec;
    vote_status_e status;
    logic [1:0]   dissent;
    logic [32:0]  voted;
    cyc = cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      abort_run($sformatf("Timeout: run still busy after %0d cycles", cyc));
    end
    if (rst_n) begin
      // Write port of the op issued two edges ago
      if (exp_q.size() != 0 && exp_q[0].cyc + 2 == cyc) begin
        rec = exp_q.pop_front();
        check_eq("wb_valid_o", 64'(wb_valid_o), 64'd1);
        check_eq("alu_waddr_fw_o", 64'(alu_waddr_fw_o), 64'(rec.waddr));
        check_eq("alu_we_fw_o", 64'(alu_we_fw_o), 64'(rec.we));
        check_eq("alu_wdata_fw_o", 64'(alu_wdata_fw_o), 64'(rec.wdata));
        check_eq("branch_decision_o", 64'(branch_decision_o), 64'(rec.br));
        check_eq("err_corrected_o", 64'(err_corrected_o), 64'(rec.corr));
        check_eq("err_detected_o", 64'(err_detected_o), 64'(rec.det));
        check_eq("fault_pulse_o", 64'(fault_pulse_o), 64'(rec.pulse));
        check_eq("fault_cnt_o", 64'(fault_cnt_o), 64'(rec.cnt));
        check_eq("perm_faulty_o", 64'(perm_faulty_o), 64'(rec.perm));
      end else begin
        check_eq("wb_valid_o", 64'(wb_valid_o), 64'd0);
        check_eq("alu_we_fw_o", 64'(alu_we_fw_o), 64'd0);
        check_eq("branch_decision_o", 64'(branch_decision_o), 64'd0);
        check_eq("err_corrected_o", 64'(err_corrected_o), 64'd0);
        check_eq("err_detected_o", 64'(err_detected_o), 64'd0);
        check_eq("fault_pulse_o", 64'(fault_pulse_o), 64'd0);
      end
      // Issue edge, enabled lanes load and the vote is predicted
      if (valid_i) begin
        for (int l = 0; l < `EX_LANES; l++) begin
          if (lane_clk_en_i[l]) model_lane[l] = alu_ref(alu_op_i, operand_a_i, operand_b_i);
        end
        voted     = vote_ref(model_lane, excl_lane_i, status, dissent);
        rec       = '0;
        rec.cyc   = cyc;
        rec.waddr = alu_waddr_i;
        rec.we    = alu_we_i;
        rec.wdata = csr_access_i ? csr_rdata_i : voted[31:0];
        rec.br    = voted[32];
        rec.corr  = status == vote_corrected;
        rec.det   = status == vote_failed;
        if (rec.corr) begin
          n_corr++;
          rec.pulse[dissent] = 1'b1;
          // Saturating count of the dissenting lane
          if (model_cnt[dissent] != '1) begin
            model_cnt[dissent] = model_cnt[dissent] + `EX_FCNT_W'd1;
          end
        end
        if (rec.det) n_det++;
        rec.cnt = model_cnt;
        for (int l = 0; l < `EX_LANES; l++) begin
          rec.perm[l] = model_cnt[l] >= `EX_FCNT_W'(`EX_PERM_THRESH);
        end
        exp_q.push_back(rec);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned start;
    void'($urandom(32'hc63d_f477));
    rst_n         = 1'b0;
    valid_i       = 1'b0;
    alu_op_i      = alu_add;
    operand_a_i   = '0;
    operand_b_i   = '0;
    alu_waddr_i   = '0;
    alu_we_i      = 1'b0;
    csr_access_i  = 1'b0;
    csr_rdata_i   = '0;
    lane_clk_en_i = '1;
    excl_lane_i   = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    // Healthy lanes under every vote selector
    for (int e = 0; e < `EX_LANES; e++) random_ops(150, 4'hf, 2'(e), 0);
    // CSR reads mixed in
    random_ops(300, 4'hf, 2'd1, 50);
    // Lane 2 stale inside the vote
    start = n_corr;
    random_ops(300, 4'b1011, 2'd0, 10);
    if (n_corr == start) abort_run("No corrected vote seen with a stale voting lane");
    // Stale lane 3 left out of the vote
    random_ops(300, 4'b0111, 2'd3, 10);
    // Lanes 1 and 2 frozen at different values, lane 0 live
    drive(1'b1, alu_add, 32'd1, 32'd1, 4'b0111, 2'd3, 1'b0);
    drive(1'b1, alu_add, 32'd5, 32'd5, 4'b0011, 2'd3, 1'b0);
    start = n_det;
    random_ops(200, 4'b0001, 2'd3, 10);
    if (n_det == start) abort_run("No failed vote seen with two stale voting lanes");
    // Lane 3 stuck at a known word until its counter saturates
    drive(1'b1, alu_add, 32'hdead_0000, 32'h0000_beef, 4'hf, 2'd0, 1'b0);
    random_ops(900, 4'b0111, 2'd0, 10);
    repeat (4) drive(1'b0, alu_add, '0, '0, 4'hf, 2'd0, 1'b0);
    while (exp_q.size() != 0) @(posedge clk);
    @(negedge clk);
    check_eq("perm_faulty_o[3]", 64'(perm_faulty_o[3]), 64'd1);
    check_eq("fault_cnt_o[3]", 64'(fault_cnt_o[3]), 64'h1ff);
    if (ex_stage_ft_i.ex_stage_ft_chk_i.fail_cnt != 0) begin
      abort_run("Bound assertion checker flagged a rule violation");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== ex_stage_ft_chk.sv ====
/* Bound checker for the FT execute stage
   Reset values of the outputs and error-flag rules */

`default_nettype none

`include "ex_defines.svh"

module ex_stage_ft_chk (
  input wire logic                                clk,
  input wire logic                                rst_n,
  input wire logic                                wb_valid_i,
  input wire logic                                alu_we_fw_i,
  input wire logic                                branch_decision_i,
  input wire logic                                err_corrected_i,
  input wire logic                                err_detected_i,
  input wire logic [`EX_LANES-1:0][`EX_FCNT_W-1:0] fault_cnt_i,
  input wire logic [`EX_LANES-1:0]                perm_faulty_i,
  input wire logic [`EX_LANES-1:0]                fault_pulse_i
);

  // Failed assertions, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // Corrected and uncorrectable are exclusive outcomes
  a_flags_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(err_corrected_i && err_detected_i))
    else begin
      $error("err_corrected_o and err_detected_o high together");
      fail_cnt++;
    end

  // Flags are pulses aligned with a write-back
  a_flags_valid: assert property (@(posedge clk) disable iff (!rst_n)
    (err_corrected_i || err_detected_i) |-> wb_valid_i)
    else begin
      $error("error flag high without wb_valid_o");
      fail_cnt++;
    end

  // All state-like outputs idle through reset, first edge skipped
  a_reset_idle: assert property (@(posedge clk) (!rst_n && $past(!rst_n)) |->
    (!wb_valid_i && !alu_we_fw_i && !branch_decision_i && !err_corrected_i &&
     !err_detected_i && fault_cnt_i == '0 && perm_faulty_i == '0 && fault_pulse_i == '0))
    else begin
      $error("output not zero while rst_n is low");
      fail_cnt++;
    end

endmodule

bind ex_stage_ft ex_stage_ft_chk ex_stage_ft_chk_i (
  .clk, .rst_n, .wb_valid_i(wb_valid_o), .alu_we_fw_i(alu_we_fw_o),
  .branch_decision_i(branch_decision_o), .err_corrected_i(err_corrected_o),
  .err_detected_i(err_detected_o), .fault_cnt_i(fault_cnt_o),
  .perm_faulty_i(perm_faulty_o), .fault_pulse_i(fault_pulse_o)
);

`default_nettype wire

// ==== ex_stage_ft.sv ====
/* Fault-tolerant execute stage top
   Issue, four ALU lanes, voter and writeback in a two-stage pipe */

`default_nettype none

`include "ex_defines.svh"

module ex_stage_ft import ex_pkg::*; (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                valid_i,
  input  wire alu_op_e                             alu_op_i,
  input  wire logic [`EX_DATA_W-1:0]               operand_a_i,
  input  wire logic [`EX_DATA_W-1:0]               operand_b_i,
  input  wire logic [`EX_REG_ADDR_W-1:0]           alu_waddr_i,
  input  wire logic                                alu_we_i,
  input  wire logic                                csr_access_i,
  input  wire logic [`EX_DATA_W-1:0]               csr_rdata_i,
  input  wire logic [`EX_LANES-1:0]                lane_clk_en_i,
  input  wire logic [`EX_LANE_IDX_W-1:0]           excl_lane_i,
  output logic                                     wb_valid_o,
  output logic [`EX_REG_ADDR_W-1:0]                alu_waddr_fw_o,
  output logic                                     alu_we_fw_o,
  output logic [`EX_DATA_W-1:0]                    alu_wdata_fw_o,
  output logic                                     branch_decision_o,
  output logic                                     err_corrected_o,
  output logic                                     err_detected_o,
  output logic [`EX_LANES-1:0][`EX_FCNT_W-1:0]     fault_cnt_o,
  output logic [`EX_LANES-1:0]                     perm_faulty_o,
  output logic [`EX_LANES-1:0]                     fault_pulse_o
);

  // Issued sideband
  logic                                 iss_valid;
  logic [`EX_REG_ADDR_W-1:0]            iss_waddr;
  logic                                 iss_we;
  logic                                 iss_csr_access;
  logic [`EX_DATA_W-1:0]                iss_csr_rdata;
  logic [`EX_LANE_IDX_W-1:0]            iss_excl_lane;
  // Lane registers and vote result
  logic [`EX_LANES-1:0][`EX_DATA_W-1:0] lane_result;
  logic [`EX_LANES-1:0]                 lane_cmp;
  logic [`EX_DATA_W-1:0]                voted_result;
  logic                                 voted_cmp;

  //////////////////////////////////////////////////////////////////////
  // Stage 1, issue and lanes
  //////////////////////////////////////////////////////////////////////

  ex_issue_stage ex_issue_stage_i (
    .clk, .rst_n, .valid_i, .alu_waddr_i, .alu_we_i, .csr_access_i, .csr_rdata_i, .excl_lane_i,
    .iss_valid_o(iss_valid), .iss_waddr_o(iss_waddr), .iss_we_o(iss_we),
    .iss_csr_access_o(iss_csr_access), .iss_csr_rdata_o(iss_csr_rdata),
    .iss_excl_lane_o(iss_excl_lane)
  );

  // Identical lanes, each with its own clock enable
  for (genvar g = 0; g < `EX_LANES; g++) begin : gen_lane
    ex_alu_lane ex_alu_lane_i (
      .clk, .rst_n, .valid_i, .clk_en_i(lane_clk_en_i[g]), .alu_op_i, .operand_a_i, .operand_b_i,
      .result_o(lane_result[g]), .cmp_o(lane_cmp[g])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 2, vote and writeback
  //////////////////////////////////////////////////////////////////////

  ex_vote_stage ex_vote_stage_i (
    .clk, .rst_n, .iss_valid_i(iss_valid), .iss_excl_lane_i(iss_excl_lane),
    .lane_result_i(lane_result), .lane_cmp_i(lane_cmp),
    .voted_result_o(voted_result), .voted_cmp_o(voted_cmp),
    .err_corrected_o, .err_detected_o, .fault_cnt_o, .perm_faulty_o, .fault_pulse_o
  );

  ex_writeback_stage ex_writeback_stage_i (
    .clk, .rst_n, .iss_valid_i(iss_valid), .iss_waddr_i(iss_waddr), .iss_we_i(iss_we),
    .iss_csr_access_i(iss_csr_access), .iss_csr_rdata_i(iss_csr_rdata),
    .voted_result_i(voted_result), .voted_cmp_i(voted_cmp),
    .wb_valid_o, .alu_waddr_fw_o, .alu_we_fw_o, .alu_wdata_fw_o, .branch_decision_o
  );

endmodule

`default_nettype wire

// ==== ex_writeback_stage.sv ====
/* Writeback stage of the FT execute path
   Muxes CSR or voted ALU data and registers the ALU write port */

`default_nettype none

`include "ex_defines.svh"

module ex_writeback_stage (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      iss_valid_i,
  input  wire logic [`EX_REG_ADDR_W-1:0] iss_waddr_i,
  input  wire logic                      iss_we_i,
  input  wire logic                      iss_csr_access_i,
  input  wire logic [`EX_DATA_W-1:0]     iss_csr_rdata_i,
  input  wire logic [`EX_DATA_W-1:0]     voted_result_i,
  input  wire logic                      voted_cmp_i,
  output logic                           wb_valid_o,
  output logic [`EX_REG_ADDR_W-1:0]      alu_waddr_fw_o,
  output logic                           alu_we_fw_o,
  output logic [`EX_DATA_W-1:0]          alu_wdata_fw_o,
  output logic                           branch_decision_o
);

  logic [`EX_DATA_W-1:0] wdata_sel;

  // CSR read data overrides the ALU result
  assign wdata_sel = iss_csr_access_i ? iss_csr_rdata_i : voted_result_i;

  //////////////////////////////////////////////////////////////////////
  // Write port register
  //////////////////////////////////////////////////////////////////////

  // Write enable and branch only valid with an op in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o        <= 1'b0;
      alu_we_fw_o       <= 1'b0;
      branch_decision_o <= 1'b0;
    end else begin
      wb_valid_o        <= iss_valid_i;
      alu_we_fw_o       <= iss_valid_i && iss_we_i;
      // Branch taken from the voted comparison bit
      branch_decision_o <= iss_valid_i && voted_cmp_i;
    end
  end

  // Address and data, meaningful only with wb_valid_o
  always_ff @(posedge clk) begin
    if (iss_valid_i) begin
      alu_waddr_fw_o <= iss_waddr_i;
      alu_wdata_fw_o <= wdata_sel;
    end
  end

endmodule

`default_nettype wire

// ==== ex_vote_stage.sv ====
/* Majority voter over three of four ALU lanes
   Flags corrected and uncorrectable outcomes, tracks per-lane faults */

`default_nettype none

`include "ex_defines.svh"

module ex_vote_stage import ex_pkg::*; (
  input  wire logic                                    clk,
  input  wire logic                                    rst_n,
  input  wire logic                                    iss_valid_i,
  input  wire logic [`EX_LANE_IDX_W-1:0]               iss_excl_lane_i,
  input  wire logic [`EX_LANES-1:0][`EX_DATA_W-1:0]    lane_result_i,
  input  wire logic [`EX_LANES-1:0]                    lane_cmp_i,
  output logic [`EX_DATA_W-1:0]                        voted_result_o,
  output logic                                         voted_cmp_o,
  output logic                                         err_corrected_o,
  output logic                                         err_detected_o,
  output logic [`EX_LANES-1:0][`EX_FCNT_W-1:0]         fault_cnt_o,
  output logic [`EX_LANES-1:0]                         perm_faulty_o,
  output logic [`EX_LANES-1:0]                         fault_pulse_o
);

  logic [`EX_LANE_IDX_W-1:0] lane_p;
  logic [`EX_LANE_IDX_W-1:0] lane_q;
  logic [`EX_LANE_IDX_W-1:0] lane_r;
  // Comparison bit on top of the result word
  logic [`EX_DATA_W:0]       val_p;
  logic [`EX_DATA_W:0]       val_q;
  logic [`EX_DATA_W:0]       val_r;
  logic                      eq_pq;
  logic                      eq_pr;
  logic                      eq_qr;
  vote_status_e              vote_status;
  logic [`EX_LANE_IDX_W-1:0] dissent_lane;
  logic [`EX_DATA_W:0]       voted;
  logic [`EX_LANES-1:0]      fault_hit;

  //////////////////////////////////////////////////////////////////////
  // Lane selection and pairwise compare
  //////////////////////////////////////////////////////////////////////

  // Voting lanes in ascending order, excluded lane skipped
  assign lane_p = (iss_excl_lane_i == `EX_LANE_IDX_W'd0) ? `EX_LANE_IDX_W'd1 : `EX_LANE_IDX_W'd0;
  assign lane_q = (iss_excl_lane_i <= `EX_LANE_IDX_W'd1) ? `EX_LANE_IDX_W'd2 : `EX_LANE_IDX_W'd1;
  assign lane_r = (iss_excl_lane_i == `EX_LANE_IDX_W'd3) ? `EX_LANE_IDX_W'd2 : `EX_LANE_IDX_W'd3;

  assign val_p = {lane_cmp_i[lane_p], lane_result_i[lane_p]};
  assign val_q = {lane_cmp_i[lane_q], lane_result_i[lane_q]};
  assign val_r = {lane_cmp_i[lane_r], lane_result_i[lane_r]};

  assign eq_pq = val_p == val_q;
  assign eq_pr = val_p == val_r;
  assign eq_qr = val_q == val_r;

  // Two-of-three decision, lane p wins a three-way split
  always_comb begin
    vote_status  = vote_failed;
    dissent_lane = lane_p;
    voted        = val_p;
    if (eq_pq && eq_qr) begin
      vote_status = vote_ok;
    end else if (eq_pq) begin
      vote_status  = vote_corrected;
      dissent_lane = lane_r;
    end else if (eq_pr) begin
      vote_status  = vote_corrected;
      dissent_lane = lane_q;
    end else if (eq_qr) begin
      vote_status  = vote_corrected;
      dissent_lane = lane_p;
      voted        = val_q;
    end
  end

  // Voted word goes straight to the writeback register
  assign {voted_cmp_o, voted_result_o} = voted;

  //////////////////////////////////////////////////////////////////////
  // Error flags and fault counters
  //////////////////////////////////////////////////////////////////////

  // One-hot dissenter, only for a real op with a corrected vote
  always_comb begin
    for (int l = 0; l < `EX_LANES; l++) begin
      fault_hit[l] = iss_valid_i && (vote_status == vote_corrected) &&
                     (dissent_lane == `EX_LANE_IDX_W'(l));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_corrected_o <= 1'b0;
      err_detected_o  <= 1'b0;
      fault_pulse_o   <= '0;
      fault_cnt_o     <= '0;
    end else begin
      // Pulses line up with wb_valid_o
      err_corrected_o <= iss_valid_i && (vote_status == vote_corrected);
      err_detected_o  <= iss_valid_i && (vote_status == vote_failed);
      fault_pulse_o   <= fault_hit;
      for (int l = 0; l < `EX_LANES; l++) begin
        // Saturating count
        if (fault_hit[l] && (fault_cnt_o[l] != {`EX_FCNT_W{1'b1}})) begin
          fault_cnt_o[l] <= fault_cnt_o[l] + `EX_FCNT_W'd1;
        end
      end
    end
  end

  // Permanent fault once the count reaches the threshold
  always_comb begin
    for (int l = 0; l < `EX_LANES; l++) begin
      perm_faulty_o[l] = fault_cnt_o[l] >= `EX_FCNT_W'(`EX_PERM_THRESH);
    end
  end

endmodule

`default_nettype wire

// ==== ex_alu_lane.sv ====
/* One redundant ALU lane
   Integer op with a result register that loads only while enabled */

`default_nettype none

`include "ex_defines.svh"

module ex_alu_lane import ex_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  valid_i,
  input  wire logic                  clk_en_i,
  input  wire alu_op_e               alu_op_i,
  input  wire logic [`EX_DATA_W-1:0] operand_a_i,
  input  wire logic [`EX_DATA_W-1:0] operand_b_i,
  output logic [`EX_DATA_W-1:0]      result_o,
  output logic                       cmp_o
);

  logic [`EX_DATA_W-1:0] alu_result;
  logic                  alu_cmp;
  logic                  a_lt_b_s;
  logic                  a_lt_b_u;
  logic                  a_eq_b;
  logic [4:0]            shamt;

  //////////////////////////////////////////////////////////////////////
  // Combinational ALU
  //////////////////////////////////////////////////////////////////////

  // Shared comparators
  assign a_lt_b_s = $signed(operand_a_i) < $signed(operand_b_i);
  assign a_lt_b_u = operand_a_i < operand_b_i;
  assign a_eq_b   = operand_a_i == operand_b_i;

  // RV32 shift amount
  assign shamt = operand_b_i[4:0];

  always_comb begin
    alu_cmp = 1'b0;
    unique case (alu_op_i)
      alu_add: alu_result = operand_a_i + operand_b_i;
      alu_sub: alu_result = operand_a_i - operand_b_i;
      alu_and: alu_result = operand_a_i & operand_b_i;
      alu_or:  alu_result = operand_a_i | operand_b_i;
      alu_xor: alu_result = operand_a_i ^ operand_b_i;
      alu_sll: alu_result = operand_a_i << shamt;
      alu_srl: alu_result = operand_a_i >> shamt;
      alu_sra: alu_result = $unsigned($signed(operand_a_i) >>> shamt);
      // Comparisons, result is the flag zero-extended
      alu_slt, alu_lt: begin
        alu_cmp    = a_lt_b_s;
        alu_result = {{(`EX_DATA_W-1){1'b0}}, a_lt_b_s};
      end
      alu_sltu, alu_ltu: begin
        alu_cmp    = a_lt_b_u;
        alu_result = {{(`EX_DATA_W-1){1'b0}}, a_lt_b_u};
      end
      alu_eq: begin
        alu_cmp    = a_eq_b;
        alu_result = {{(`EX_DATA_W-1){1'b0}}, a_eq_b};
      end
      alu_ne: begin
        alu_cmp    = !a_eq_b;
        alu_result = {{(`EX_DATA_W-1){1'b0}}, !a_eq_b};
      end
      alu_ge: begin
        alu_cmp    = !a_lt_b_s;
        alu_result = {{(`EX_DATA_W-1){1'b0}}, !a_lt_b_s};
      end
      alu_geu: begin
        alu_cmp    = !a_lt_b_u;
        alu_result = {{(`EX_DATA_W-1){1'b0}}, !a_lt_b_u};
      end
      default: alu_result = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Gated result register
  //////////////////////////////////////////////////////////////////////

  // Disabled lane keeps its stale value, seen as a fault by the voter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_o <= '0;
      cmp_o    <= 1'b0;
    end else if (valid_i && clk_en_i) begin
      result_o <= alu_result;
      cmp_o    <= alu_cmp;
    end
  end

endmodule

`default_nettype wire

// ==== ex_issue_stage.sv ====
/* Issue stage of the FT execute path
   Captures write-back sideband and vote selector of each issued op */

`default_nettype none

`include "ex_defines.svh"

module ex_issue_stage (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      valid_i,
  input  wire logic [`EX_REG_ADDR_W-1:0] alu_waddr_i,
  input  wire logic                      alu_we_i,
  input  wire logic                      csr_access_i,
  input  wire logic [`EX_DATA_W-1:0]     csr_rdata_i,
  input  wire logic [`EX_LANE_IDX_W-1:0] excl_lane_i,
  output logic                           iss_valid_o,
  output logic [`EX_REG_ADDR_W-1:0]      iss_waddr_o,
  output logic                           iss_we_o,
  output logic                           iss_csr_access_o,
  output logic [`EX_DATA_W-1:0]          iss_csr_rdata_o,
  output logic [`EX_LANE_IDX_W-1:0]      iss_excl_lane_o
);

  //////////////////////////////////////////////////////////////////////
  // Control sideband
  //////////////////////////////////////////////////////////////////////

  // One strobe per op, idle cycles drop valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      iss_valid_o      <= 1'b0;
      iss_we_o         <= 1'b0;
      iss_csr_access_o <= 1'b0;
      iss_excl_lane_o  <= '0;
    end else begin
      iss_valid_o <= valid_i;
      // Hold op fields between strobes
      if (valid_i) begin
        iss_we_o         <= alu_we_i;
        iss_csr_access_o <= csr_access_i;
        // Vote selector frozen at issue
        iss_excl_lane_o  <= excl_lane_i;
      end
    end
  end

  // Payload fields, loaded with the strobe
  always_ff @(posedge clk) begin
    if (valid_i) begin
      iss_waddr_o     <= alu_waddr_i;
      iss_csr_rdata_o <= csr_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== ex_pkg.sv ====
/* Execute stage FT types
   ALU opcodes and majority vote outcome */

`default_nettype none

package ex_pkg;

  // ALU opcodes
  // Comparison group sets the comparison bit, slt and sltu included
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9,
    alu_eq   = 4'd10,
    alu_ne   = 4'd11,
    alu_lt   = 4'd12,
    alu_ge   = 4'd13,
    alu_ltu  = 4'd14,
    alu_geu  = 4'd15
  } alu_op_e;

  // Outcome of the three-lane vote
  typedef enum logic [1:0] {
    vote_ok        = 2'd0,
    vote_corrected = 2'd1,
    vote_failed    = 2'd2
  } vote_status_e;

endpackage

`default_nettype wire

// ==== ex_defines.svh ====
/* Execute stage FT shared macros
   Datapath widths, lane count and fault-counter limits */

`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Operand and result width
`define EX_DATA_W 32

// Redundant ALU lanes, one left out of each vote
`define EX_LANES 4

// Width of a lane index
`define EX_LANE_IDX_W 2

// Register file write address width
`define EX_REG_ADDR_W 6

// Per-lane fault counter width, saturates at all ones
`define EX_FCNT_W 9

// Counter value from which a lane counts as permanently faulty
`define EX_PERM_THRESH 8

`endif
